/* hdl/lsu_pkg.sv */
// Load/store encoding with data widths, funct3 codes and the core-side request and response.
`default_nettype none

package lsu_pkg;

    localparam int XLEN   = 64;           // Data word width.
    localparam int AWIDTH = 32;           // Byte address width.
    localparam int STRB_W = XLEN / 8;     // One strobe bit per byte lane.

    typedef logic [XLEN-1:0]           xlen_t;
    typedef logic [AWIDTH-1:0]         addr_t;
    typedef logic [STRB_W-1:0]         strb_t;
    typedef logic [$clog2(STRB_W)-1:0] boff_t;   // Byte offset inside a doubleword.

    // RISC-V load width codes.
    typedef enum logic [2:0] {
        LB  = 3'd0,
        LH  = 3'd1,
        LW  = 3'd2,
        LD  = 3'd3,
        LBU = 3'd4,
        LHU = 3'd5,
        LWU = 3'd6
    } funct3_e;

    // Stores share the lower four codes.
    localparam funct3_e SB = LB;
    localparam funct3_e SH = LH;
    localparam funct3_e SW = LW;
    localparam funct3_e SD = LD;

    typedef struct packed {
        logic    write;        // 1 for a store.
        funct3_e funct3;
        addr_t   addr;
        xlen_t   wdata;        // Store data, not yet in its byte lanes.
    } lsu_req_t;

    typedef struct packed {
        xlen_t rdata;          // Extended load result.
        logic  err;
    } lsu_rsp_t;

endpackage

`default_nettype wire

/* hdl/bus_pkg.sv */
// APB request and response for the LSU bus, with the address map of the RAM and the device.
`default_nettype none

package bus_pkg;

    typedef struct packed {
        logic           psel_ram;
        logic           psel_dev;
        logic           penable;
        logic           pwrite;
        lsu_pkg::addr_t paddr;     // Always doubleword aligned.
        lsu_pkg::xlen_t pwdata;    // Already in its byte lanes.
        lsu_pkg::strb_t pstrb;
    } apb_req_t;

    typedef struct packed {
        logic           pready;
        lsu_pkg::xlen_t prdata;
        logic           pslverr;
    } apb_rsp_t;

    // Regions decode on the top address nibble.
    localparam lsu_pkg::addr_t ram_base = 32'h8000_0000;
    localparam lsu_pkg::addr_t dev_base = 32'hA000_0000;

    localparam int dev_regs = 4;   // Scratch registers in the device region.

endpackage

`default_nettype wire

/* hdl/lsu_store_align.sv */
// Store alignment that moves store data into its byte lanes and builds the byte strobe.
`default_nettype none
`timescale 1ns/1ps

module lsu_store_align (
    input  lsu_pkg::funct3_e funct3,
    input  lsu_pkg::boff_t   boff,
    input  lsu_pkg::xlen_t   wdata,
    output lsu_pkg::xlen_t   lane_data,
    output lsu_pkg::strb_t   strb
);
    import lsu_pkg::*;

    strb_t                base;        // Strobe at lane 0.
    logic [2*STRB_W-1:0]  strb_wide;   // Room for lanes pushed past lane 7.
    logic                 misalign;

    always_comb begin
        case (funct3)
            SB: begin
                base     = 8'h01;
                misalign = 1'b0;
            end
            SH: begin
                base     = 8'h03;
                misalign = boff[0];
            end
            SW: begin
                base     = 8'h0F;
                misalign = |boff[1:0];
            end
            SD: begin
                base     = 8'hFF;
                misalign = |boff;
            end
            default: begin
                base     = 8'h00;          // Load-only codes write nothing.
                misalign = 1'b0;
            end
        endcase
    end

    assign lane_data = wdata << {boff, 3'b000};
    assign strb_wide = {{STRB_W{1'b0}}, base} << boff;
    assign strb      = strb_wide[STRB_W-1:0];

    // An aligned store always fits inside the doubleword.
    always_comb begin
        if (!$isunknown({funct3, boff})) begin
            assert final (misalign || (strb_wide[2*STRB_W-1:STRB_W] == '0))
                else $error("Store strobe spans past lane 7");
        end
    end

endmodule

`default_nettype wire

/* hdl/lsu_load_extend.sv */
// Load extension that shifts the read doubleword down and sign or zero extends it per funct3.
`default_nettype none
`timescale 1ns/1ps

module lsu_load_extend (
    input  lsu_pkg::funct3_e funct3,
    input  lsu_pkg::boff_t   boff,
    input  lsu_pkg::xlen_t   raw,
    input  logic             en,
    output lsu_pkg::xlen_t   rdata
);
    import lsu_pkg::*;

    xlen_t sh;    // Addressed byte moved to lane 0.

    assign sh = raw >> {boff, 3'b000};

    always_comb begin
        if (!en) begin
            rdata = '0;
        end else begin
            case (funct3)
                LB: begin
                    rdata = {{(XLEN-8){sh[7]}}, sh[7:0]};
                end
                LH: begin
                    rdata = {{(XLEN-16){sh[15]}}, sh[15:0]};
                end
                LW: begin
                    rdata = {{(XLEN-32){sh[31]}}, sh[31:0]};
                end
                LD: begin
                    rdata = sh;
                end
                LBU: begin
                    rdata = {{(XLEN-8){1'b0}}, sh[7:0]};
                end
                LHU: begin
                    rdata = {{(XLEN-16){1'b0}}, sh[15:0]};
                end
                LWU: begin
                    rdata = {{(XLEN-32){1'b0}}, sh[31:0]};
                end
                default: begin
                    rdata = '0;                  // Unused code.
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/lsu_ctrl.sv */
// LSU control FSM that accepts a request, checks it, runs the APB transfer and returns the response.
`default_nettype none
`timescale 1ns/1ps

module lsu_ctrl #(
    parameter int RAM_DEPTH = 256
) (
    input  logic               clk,
    input  logic               rst,
    input  lsu_pkg::lsu_req_t  req,
    input  logic               req_valid,
    output logic               req_ready,
    output logic               rsp_valid,
    output logic               rsp_err,
    output lsu_pkg::funct3_e   cur_funct3,
    output lsu_pkg::boff_t     cur_boff,
    input  lsu_pkg::xlen_t     st_data,
    input  lsu_pkg::strb_t     st_strb,
    output lsu_pkg::xlen_t     cur_wdata,
    output lsu_pkg::xlen_t     ld_raw,
    output bus_pkg::apb_req_t  apb_req,
    input  bus_pkg::apb_rsp_t  ram_rsp,
    input  bus_pkg::apb_rsp_t  dev_rsp
);
    import lsu_pkg::*;
    import bus_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS,
        RESP
    } state_e;

    state_e   state;
    lsu_req_t cur;          // Request held for the whole transfer.
    logic     to_dev;       // Held region of the current access.
    logic     err_q;
    logic     accept;
    logic     aligned;
    logic     code_ok;
    logic     ram_hit;
    logic     dev_hit;
    logic     legal;
    logic     in_bus;
    logic     done;
    apb_rsp_t sel_rsp;

    // RESP is idle with a response on the port, so it takes a new request too.
    assign req_ready = (state == IDLE) || (state == RESP);
    assign accept    = req_valid && req_ready;

    // Natural alignment for the access width.
    always_comb begin
        case (req.funct3[1:0])
            2'd0:    aligned = 1'b1;
            2'd1:    aligned = (req.addr[0] == 1'b0);
            2'd2:    aligned = (req.addr[1:0] == 2'b00);
            default: aligned = (req.addr[2:0] == 3'b000);
        endcase
    end

    assign code_ok = req.write ? (req.funct3[2] == 1'b0) : (req.funct3 != 3'd7);
    assign ram_hit = (req.addr[31:28] == ram_base[31:28]) && (req.addr[27:3] < RAM_DEPTH);
    assign dev_hit = (req.addr[31:28] == dev_base[31:28]) && (req.addr[27:3] < dev_regs);
    assign legal   = aligned && code_ok && (ram_hit || dev_hit);

    assign in_bus  = (state == SETUP) || (state == ACCESS);
    assign sel_rsp = to_dev ? dev_rsp : ram_rsp;
    assign done    = (state == ACCESS) && sel_rsp.pready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            err_q <= 1'b0;
        end else begin
            case (state)
                IDLE, RESP: begin
                    if (accept) begin
                        state <= legal ? SETUP : RESP;   // Bad access skips the bus.
                        err_q <= !legal;
                    end else begin
                        state <= IDLE;
                    end
                end
                SETUP: begin
                    state <= ACCESS;
                end
                ACCESS: begin
                    if (done) begin
                        state <= RESP;
                        err_q <= sel_rsp.pslverr;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Held request and load data.
    always_ff @(posedge clk) begin
        if (accept) begin
            cur    <= req;
            to_dev <= dev_hit;
            ld_raw <= '0;                     // Stores and errors read back zero.
        end else if (done && !cur.write && !sel_rsp.pslverr) begin
            ld_raw <= sel_rsp.prdata;
        end
    end

    assign rsp_valid  = (state == RESP);
    assign rsp_err    = rsp_valid && err_q;
    assign cur_funct3 = cur.funct3;
    assign cur_boff   = cur.addr[2:0];
    assign cur_wdata  = cur.wdata;

    always_comb begin
        apb_req.psel_ram = in_bus && !to_dev;
        apb_req.psel_dev = in_bus && to_dev;
        apb_req.penable  = (state == ACCESS);
        apb_req.pwrite   = cur.write;
        apb_req.paddr    = {cur.addr[31:3], 3'b000};
        apb_req.pwdata   = st_data;
        apb_req.pstrb    = cur.write ? st_strb : '0;   // No lanes on a read.
    end

    // Nothing on the bus but penable may move from setup to completion.
    ap_apb_stable: assert property (@(posedge clk) disable iff (rst)
        apb_req.penable |-> $stable({apb_req.psel_ram, apb_req.psel_dev, apb_req.pwrite,
                                     apb_req.paddr, apb_req.pwdata, apb_req.pstrb}))
        else $error("APB fields changed during the access phase");

    // The one select must also match the region of the address on the bus.
    ap_one_select: assert property (@(posedge clk) disable iff (rst)
        apb_req.penable |-> ($onehot({apb_req.psel_ram, apb_req.psel_dev}) &&
                             (apb_req.psel_dev == (apb_req.paddr[31:28] == dev_base[31:28]))))
        else $error("Access phase without exactly one select for its region");

endmodule

`default_nettype wire

/* hdl/lsu_apb_ram.sv */
// APB slave RAM of 64-bit words with byte-strobe writes and no wait states.
`default_nettype none
`timescale 1ns/1ps

module lsu_apb_ram #(
    parameter int RAM_DEPTH = 256
) (
    input  logic              clk,
    input  logic              rst,
    input  bus_pkg::apb_req_t apb_req,
    output bus_pkg::apb_rsp_t apb_rsp
);
    import lsu_pkg::*;

    localparam int IDX_W = (RAM_DEPTH > 1) ? $clog2(RAM_DEPTH) : 1;

    xlen_t            mem [RAM_DEPTH];
    logic [IDX_W-1:0] idx;
    logic             wr;

    assign idx = apb_req.paddr[IDX_W+2:3];     // Word index above the byte offset.
    assign wr  = apb_req.psel_ram && apb_req.penable && apb_req.pwrite;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < RAM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (apb_req.pstrb[b]) begin
                    mem[idx][8*b +: 8] <= apb_req.pwdata[8*b +: 8];
                end
            end
        end
    end

    // Read is combinational, so every access completes at once.
    always_comb begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.prdata  = mem[idx];
        apb_rsp.pslverr = 1'b0;
    end

    // The region check upstream must keep the index inside the array.
    ap_idx_range: assert property (@(posedge clk) disable iff (rst)
        apb_req.psel_ram |-> (apb_req.paddr[27:3] < RAM_DEPTH))
        else $error("RAM selected with word index beyond RAM_DEPTH");

endmodule

`default_nettype wire

/* hdl/lsu_apb_dev.sv */
// APB slave with four 64-bit scratch registers, byte-strobe writes and a fixed wait count.
`default_nettype none
`timescale 1ns/1ps

module lsu_apb_dev #(
    parameter int DEV_WAIT = 1
) (
    input  logic              clk,
    input  logic              rst,
    input  bus_pkg::apb_req_t apb_req,
    output bus_pkg::apb_rsp_t apb_rsp
);
    import lsu_pkg::*;
    import bus_pkg::*;

    localparam int CNT_W = (DEV_WAIT > 0) ? $clog2(DEV_WAIT + 1) : 1;
    localparam int IDX_W = $clog2(dev_regs);

    xlen_t            regs [dev_regs];
    logic [CNT_W-1:0] wait_cnt;     // Access cycles spent so far.
    logic [IDX_W-1:0] idx;
    logic             access;
    logic             done;

    assign idx    = apb_req.paddr[IDX_W+2:3];
    assign access = apb_req.psel_dev && apb_req.penable;
    assign done   = access && (wait_cnt == CNT_W'(DEV_WAIT));

    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt <= '0;
        end else if (access && !done) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;                  // Ready for the next transfer.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < dev_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (done && apb_req.pwrite) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (apb_req.pstrb[b]) begin
                    regs[idx][8*b +: 8] <= apb_req.pwdata[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        apb_rsp.pready  = done;
        apb_rsp.prdata  = done ? regs[idx] : '0;   // Data only on the completing cycle.
        apb_rsp.pslverr = 1'b0;
    end

    // Each access phase lasts exactly DEV_WAIT extra cycles while the master holds it.
    ap_wait_len: assert property (@(posedge clk) disable iff (rst)
        $rose(access) |-> ##DEV_WAIT apb_rsp.pready)
        else $error("Device completion not after DEV_WAIT wait states");

endmodule

`default_nettype wire

/* hdl/lsu_top.sv */
// LSU top level joining the control FSM, both datapaths and the RAM and device APB slaves.
`default_nettype none
`timescale 1ns/1ps

module lsu_top #(
    parameter int RAM_DEPTH = 256,
    parameter int DEV_WAIT  = 1
) (
    input  logic              clk,
    input  logic              rst,
    input  lsu_pkg::lsu_req_t req,
    input  logic              req_valid,
    output logic              req_ready,
    output lsu_pkg::lsu_rsp_t rsp,
    output logic              rsp_valid
);
    import lsu_pkg::*;
    import bus_pkg::*;

    funct3_e  cur_funct3;
    boff_t    cur_boff;
    xlen_t    cur_wdata;
    xlen_t    st_data;
    strb_t    st_strb;
    xlen_t    ld_raw;
    xlen_t    ld_rdata;
    logic     rsp_err;
    apb_req_t apb_req;
    apb_rsp_t ram_rsp;
    apb_rsp_t dev_rsp;

    assign rsp = '{rdata: ld_rdata, err: rsp_err};

    lsu_ctrl #(
        .RAM_DEPTH (RAM_DEPTH)
    ) u_lsu_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .rsp_valid  (rsp_valid),
        .rsp_err    (rsp_err),
        .cur_funct3 (cur_funct3),
        .cur_boff   (cur_boff),
        .st_data    (st_data),
        .st_strb    (st_strb),
        .cur_wdata  (cur_wdata),
        .ld_raw     (ld_raw),
        .apb_req    (apb_req),
        .ram_rsp    (ram_rsp),
        .dev_rsp    (dev_rsp)
    );

    lsu_store_align u_lsu_store_align (
        .funct3    (cur_funct3),
        .boff      (cur_boff),
        .wdata     (cur_wdata),
        .lane_data (st_data),
        .strb      (st_strb)
    );

    lsu_load_extend u_lsu_load_extend (
        .funct3 (cur_funct3),
        .boff   (cur_boff),
        .raw    (ld_raw),
        .en     (rsp_valid),      // Raw data is zero for stores and errors.
        .rdata  (ld_rdata)
    );

    lsu_apb_ram #(
        .RAM_DEPTH (RAM_DEPTH)
    ) u_lsu_apb_ram (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (ram_rsp)
    );

    lsu_apb_dev #(
        .DEV_WAIT (DEV_WAIT)
    ) u_lsu_apb_dev (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (dev_rsp)
    );

endmodule

`default_nettype wire

/* sim/lsu_tb.sv */
// LSU testbench that runs random loads and stores against shadow memories and checks each response.
`default_nettype none
`timescale 1ns/1ps

module lsu_tb;
    import lsu_pkg::*;
    import bus_pkg::*;

    localparam int RAM_DEPTH = 256;
    localparam int DEV_WAIT  = 1;
    localparam int TIMEOUT   = 64;       // Cycles allowed for any single wait.

    logic     clk;
    logic     rst;
    lsu_req_t req;
    logic     req_valid;
    logic     req_ready;
    lsu_rsp_t rsp;
    logic     rsp_valid;

    logic [15:0] lfsr;
    xlen_t       ram_sh [RAM_DEPTH];    // Shadow of the RAM contents.
    xlen_t       dev_sh [dev_regs];     // Shadow of the device registers.
    lsu_rsp_t    exp_q [$];             // Expected responses, oldest first.
    int          checks;
    int          errors;
    int          err_mark;
    int          test_no;
    int          nreq;
    int          nrsp;

    lsu_top #(
        .RAM_DEPTH (RAM_DEPTH),
        .DEV_WAIT  (DEV_WAIT)
    ) u_lsu_top (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid)
    );

    always #4 clk = ~clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;            // Taps 16, 14, 13, 11.
        end
        return n;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int width_bytes(input funct3_e f3);
        return 1 << f3[1:0];
    endfunction

    // Random byte offset that is naturally aligned for the width.
    function automatic addr_t aligned_off(input funct3_e f3);
        addr_t off;
        off = addr_t'(rand_bits(3));
        return off & ~addr_t'(width_bytes(f3) - 1);
    endfunction

    function automatic lsu_req_t make_req(input logic write, input funct3_e f3,
                                          input addr_t addr, input xlen_t wdata);
        lsu_req_t r;
        r.write  = write;
        r.funct3 = f3;
        r.addr   = addr;
        r.wdata  = wdata;
        return r;
    endfunction

    // Applies one access to the shadow memories and returns the response it must give.
    function automatic lsu_rsp_t model_access(input lsu_req_t r);
        lsu_rsp_t res;
        int       size;
        int       off;
        int       word;
        logic     sgn;
        logic     legal;
        logic     to_dev;
        xlen_t    line;
        res  = '0;
        size = width_bytes(r.funct3);
        sgn  = !r.funct3[2] && (r.funct3 != LD);
        off  = r.addr[2:0];
        word = r.addr[27:3];
        legal = (off % size) == 0;
        if (r.funct3 == 3'd7 || (r.write && r.funct3[2])) begin
            legal = 1'b0;                // No such width.
        end
        to_dev = (r.addr[31:28] == dev_base[31:28]);
        if (to_dev) begin
            legal = legal && (word < dev_regs);
        end else if (r.addr[31:28] == ram_base[31:28]) begin
            legal = legal && (word < RAM_DEPTH);
        end else begin
            legal = 1'b0;
        end
        if (!legal) begin
            res.err = 1'b1;
            return res;
        end
        line = to_dev ? dev_sh[word] : ram_sh[word];
        if (r.write) begin
            for (int i = 0; i < size; i++) begin
                line[8*(off+i) +: 8] = r.wdata[8*i +: 8];
            end
            if (to_dev) begin
                dev_sh[word] = line;
            end else begin
                ram_sh[word] = line;
            end
        end else begin
            for (int i = 0; i < size; i++) begin
                res.rdata[8*i +: 8] = line[8*(off+i) +: 8];
            end
            for (int i = 8*size; i < 64; i++) begin
                res.rdata[i] = sgn & res.rdata[8*size-1];
            end
        end
        return res;
    endfunction

    task automatic check_value(input string name, input xlen_t exp, input xlen_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic abort_run(input string msg);
        errors++;
        $display("%s", msg);
        $display("checks %0d, errors %0d, requests %0d, responses %0d",
                 checks, errors, nreq, nrsp);
        $display("Test failed");
        $finish;
    endtask

    // Drives one request and returns on the edge where it is accepted.
    task automatic send_req(input lsu_req_t r, input logic hold);
        int   waited;
        logic accepted;
        exp_q.push_back(model_access(r));
        nreq++;
        req       <= r;
        req_valid <= 1'b1;
        waited    = 0;
        do begin
            @(posedge clk);
            waited++;
            accepted = req_ready;
        end while (!accepted && waited < TIMEOUT);
        if (!accepted) begin
            abort_run("Request was never accepted before the timeout");
        end else if (!hold) begin
            req_valid <= 1'b0;
        end
    endtask

    task automatic wait_responses();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            abort_run("No response arrived before the timeout");
        end
    endtask

    task automatic do_access(input lsu_req_t r);
        send_req(r, 1'b0);
        wait_responses();
    endtask

    task automatic end_test(input string name);
        $display("test %0d %s: %0d errors", test_no, name, errors - err_mark);
        test_no++;
        err_mark = errors;
    endtask

    // Each response must match the oldest outstanding request.
    always @(posedge clk) begin : compare_rsp
        lsu_rsp_t exp;
        if (!rst && rsp_valid) begin
            nrsp++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Response at %0t with no request outstanding", $time);
            end else begin
                exp = exp_q.pop_front();
                check_value("rsp.rdata", exp.rdata, rsp.rdata);
                check_value("rsp.err", xlen_t'(exp.err), xlen_t'(rsp.err));
            end
        end
    end

    initial begin : main
        funct3_e f3;
        addr_t   base;
        lsu_req_t r;
        clk       = 1'b0;
        rst       = 1'b1;
        req       = '0;
        req_valid = 1'b0;
        lfsr      = 16'd4846;
        checks    = 0;
        errors    = 0;
        err_mark  = 0;
        test_no   = 1;
        nreq      = 0;
        nrsp      = 0;
        for (int i = 0; i < RAM_DEPTH; i++) begin
            ram_sh[i] = '0;
        end
        for (int i = 0; i < dev_regs; i++) begin
            dev_sh[i] = '0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        check_value("req_ready", 64'd1, xlen_t'(req_ready));
        check_value("rsp_valid", 64'd0, xlen_t'(rsp_valid));
        do_access(make_req(1'b0, LD, ram_base, '0));
        end_test("reset");

        for (int n = 0; n < 16; n++) begin
            f3   = funct3_e'(3'(rand_bits(2)));
            base = ram_base | addr_t'(rand_bits($clog2(RAM_DEPTH)) << 3);
            do_access(make_req(1'b1, f3, base | aligned_off(f3), rand_bits(64)));
            for (int c = 0; c < 7; c++) begin
                f3 = funct3_e'(c);
                do_access(make_req(1'b0, f3, base | aligned_off(f3), '0));
            end
        end
        end_test("ram");

        for (int d = 0; d < dev_regs; d++) begin
            base = dev_base | addr_t'(d << 3);
            do_access(make_req(1'b1, SD, base, rand_bits(64)));
            do_access(make_req(1'b1, SB, base | aligned_off(SB), rand_bits(64)));
            for (int c = 0; c < 7; c++) begin
                f3 = funct3_e'(c);
                do_access(make_req(1'b0, f3, base | aligned_off(f3), '0));
            end
        end
        end_test("device");

        do_access(make_req(1'b0, LH, ram_base | 32'h11, '0));   // Odd halfword.
        do_access(make_req(1'b1, SW, ram_base | 32'h12, rand_bits(64)));
        do_access(make_req(1'b1, SD, dev_base | 32'h01, rand_bits(64)));
        do_access(make_req(1'b0, LD, ram_base | 32'h10, '0));
        do_access(make_req(1'b0, LD, dev_base, '0));
        end_test("misaligned");

        do_access(make_req(1'b0, LD, 32'h0000_0000, '0));
        do_access(make_req(1'b1, SD, ram_base + addr_t'(RAM_DEPTH * 8), rand_bits(64)));
        do_access(make_req(1'b0, LW, dev_base | 32'h20, '0));
        do_access(make_req(1'b0, LB, 32'h9000_0000, '0));
        end_test("unmapped");

        for (int n = 0; n < 12; n++) begin
            f3   = funct3_e'(3'(rand_bits(2)));
            base = (rand_bits(1) ? dev_base : ram_base) | addr_t'(rand_bits(2) << 3);
            case (int'(rand_bits(2)))
                0:       r = make_req(1'b1, f3, base | aligned_off(f3), rand_bits(64));
                1:       r = make_req(1'b0, LH, base | 32'h3, '0);
                default: r = make_req(1'b0, f3, base | aligned_off(f3), '0);
            endcase
            send_req(r, n != 11);
        end
        wait_responses();
        end_test("back_to_back");

        check_value("response count", xlen_t'(nreq), xlen_t'(nrsp));
        $display("checks %0d, errors %0d, requests %0d, responses %0d",
                 checks, errors, nreq, nrsp);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* lsu_subsys.f */
hdl/lsu_pkg.sv
hdl/bus_pkg.sv
hdl/lsu_store_align.sv
hdl/lsu_load_extend.sv
hdl/lsu_ctrl.sv
hdl/lsu_apb_ram.sv
hdl/lsu_apb_dev.sv
hdl/lsu_top.sv
sim/lsu_tb.sv
